//--- l2_cache_ctrl.f
verilog/l2_cache_pkg.sv
verilog/mem_cmd_if.sv
verilog/l2_access_fsm.sv
verilog/l2_victim_track.sv
verilog/l2_mem_cmd.sv
verilog/l2_cache_ctrl.sv
verif/tb_l2_models.sv
verif/tb_l2_cache_ctrl.sv

//--- verif/tb_l2_cache_ctrl.sv
`timescale 1ns/1ps

module tb_l2_cache_ctrl import l2_cache_pkg::*; ();

	localparam int                NUM_TESTS       = 6;
	localparam int                CYCLES_PER_TEST = 400;
	localparam int                CLK_PERIOD      = 8;
	localparam logic [DATA_W-1:0] FILL_PATTERN    = 32'h5a3c_96e1;

	logic clock_i, resetn_i, enable_i;
	logic L1_req_i, L1_rw_i, L2_ready_read_i, L2_ready_write_i;
	logic [TAG_W-1:0] L1_tag_i, cam_tag_i;
	logic [DATA_W-1:0] L1_data_i, cache_mem_data_i, cache_mem_data_o, buffer_data_i, buffer_data_o;
	logic L1_done_o, L1_hit_o, L1_valid_o, L2_read_ack_o;
	logic cam_hit_i, cam_wren_o;
	logic [LINE_W-1:0] cam_addr_i, cam_addr_o;
	logic [CMEM_ADDR_W-1:0] cache_mem_add_o;
	logic cache_mem_rw_o;
	logic buffer_read_ready_i, buffer_read_ack_o, buffer_write_ready_i, buffer_write_ack_o;
	logic mem_ready_i, mem_req_o, mem_req_block_o, mem_rw_o;
	logic [WORD_ADDR_W-1:0] mem_addr_o;
	logic flag_hit_o, flag_miss_o, flag_writeback_o;

	// monitor logs cleared per test
	logic [CMEM_ADDR_W-1:0] v_addr [0:15];
	logic [DATA_W-1:0]      v_data [0:15];
	logic [WORD_ADDR_W-1:0] cmd_addr [0:15];
	logic                   cmd_rw [0:15];
	logic                   cmd_blk [0:15];
	logic [LINE_W-1:0]      cam_line [0:15];
	int v_cnt, cmd_cnt, cam_cnt, ack_cnt, hit_cnt, miss_cnt, wb_cnt;
	logic [DATA_W-1:0] l1_tx [0:3];     // block L1 sends
	logic [DATA_W-1:0] wh_words [0:3];  // written by the write hit
	logic [DATA_W-1:0] wm_words [0:3];  // written by the write miss
	logic [TAG_W-1:0]  tags [0:8];
	int l1_idx;

	l2_cache_ctrl DUT (.*);

	tb_l2_models #(.FILL_PATTERN(FILL_PATTERN)) models (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.match_tag_i(L1_tag_i), .hit_o(cam_hit_i), .hit_line_o(cam_addr_i),
		.sel_line_i(cam_addr_o), .sel_tag_o(cam_tag_i), .wren_i(cam_wren_o),
		.cmem_add_i(cache_mem_add_o), .cmem_rw_i(cache_mem_rw_o),
		.cmem_wdata_i(cache_mem_data_o), .cmem_rdata_o(cache_mem_data_i),
		.rbuf_ready_o(buffer_read_ready_i), .rbuf_data_o(buffer_data_i),
		.rbuf_ack_i(buffer_read_ack_o), .wbuf_ready_o(buffer_write_ready_i),
		.wbuf_data_i(buffer_data_o), .wbuf_ack_i(buffer_write_ack_o),
		.mem_req_i(mem_req_o), .mem_rw_i(mem_rw_o), .mem_addr_i(mem_addr_o)
	);

	initial begin
		clock_i = 1'b0;
		forever #(CLK_PERIOD / 2) clock_i = ~clock_i;
	end

	initial begin  // watchdog
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("watchdog expired, a transfer never completed");
		$display("** FAIL **");
		$fatal(1, "timeout");
	end

	// --------------------------------------------------
	// monitors sample registered outputs at the edge
	always @(posedge clock_i) begin
		if (L1_valid_o) begin
			v_addr[v_cnt] = cache_mem_add_o;
			v_data[v_cnt] = cache_mem_data_i;  // word L1 takes
			v_cnt = v_cnt + 1;
		end
		if (mem_req_o) begin
			cmd_addr[cmd_cnt] = mem_addr_o;
			cmd_rw[cmd_cnt]   = mem_rw_o;
			cmd_blk[cmd_cnt]  = mem_req_block_o;
			cmd_cnt = cmd_cnt + 1;
		end
		if (cam_wren_o) begin
			cam_line[cam_cnt] = cam_addr_o;
			cam_cnt = cam_cnt + 1;
		end
		ack_cnt  = ack_cnt + L2_read_ack_o;
		hit_cnt  = hit_cnt + flag_hit_o;
		miss_cnt = miss_cnt + flag_miss_o;
		wb_cnt   = wb_cnt + flag_writeback_o;
	end

	// L1 transmit side moves to the next word once the ack shows
	always @(posedge clock_i) begin
		#1;
		if (L2_read_ack_o && l1_idx < 4) begin
			l1_idx = l1_idx + 1;
			if (l1_idx == 4)
				L2_ready_read_i = 1'b0;
			else
				L1_data_i = l1_tx[l1_idx];
		end
	end

	// --------------------------------------------------
	task automatic tick();
		@(posedge clock_i);
		#1;
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("** Error %s: got %h expected %h", name, got, exp);
			$display("** FAIL **");
			$fatal(1, "mismatch");
		end
	endtask

	function automatic logic [DATA_W-1:0] fill_word(input logic [WORD_ADDR_W-1:0] addr);
		return {8'h00, addr} ^ FILL_PATTERN;  // main memory contents rule
	endfunction

	task automatic clear_logs();
		v_cnt    = 0;
		cmd_cnt  = 0;
		cam_cnt  = 0;
		ack_cnt  = 0;
		hit_cnt  = 0;
		miss_cnt = 0;
		wb_cnt   = 0;
	endtask

	task automatic load_l1_block();
		for (int i = 0; i < 4; i++)
			l1_tx[i] = $urandom;
		l1_idx = 0;
		L1_data_i = l1_tx[0];
		L2_ready_read_i = 1'b1;
	endtask

	task automatic wait_done();
		do tick(); while (!L1_done_o);
		repeat (3) tick();  // let the FSM reach NORMAL and the writeback go out
	endtask

	task automatic issue_req(input logic rw, input logic [TAG_W-1:0] tag, input logic hit);
		L1_tag_i = tag;  // held for the replay after a miss
		L1_rw_i  = rw;
		L1_req_i = 1'b1;
		tick();
		L1_req_i = 1'b0;
		check_value("L1_done_o", L1_done_o, 0);
		check_value("L1_hit_o", L1_hit_o, hit);
		wait_done();
	endtask

	task automatic check_stream(input logic [LINE_W-1:0] line, input logic [DATA_W-1:0] w [0:3]);
		check_value("L1_valid_o count", v_cnt, 4);
		for (int i = 0; i < 4; i++) begin
			check_value("cache_mem_add_o", v_addr[i], {line, 2'(i)});
			check_value("L1 read data", v_data[i], w[i]);
		end
	endtask

	task automatic read_miss_expect(input logic [TAG_W-1:0] tag, input logic [LINE_W-1:0] line);
		logic [DATA_W-1:0] w [0:3];
		for (int i = 0; i < 4; i++)
			w[i] = fill_word({tag, 2'(i)});
		clear_logs();
		L2_ready_write_i = 1'b1;
		issue_req(1'b0, tag, 1'b0);
		check_value("flag_miss_o count", miss_cnt, 1);
		check_value("flag_hit_o count", hit_cnt, 0);
		check_value("mem_req_o count", cmd_cnt, 1);
		check_value("mem_rw_o", cmd_rw[0], 0);
		check_value("mem_req_block_o", cmd_blk[0], 1);
		check_value("mem_addr_o", cmd_addr[0], {tag, 2'b00});
		check_value("cam_wren_o count", cam_cnt, 1);
		check_value("cam_addr_o", cam_line[0], line);
		for (int i = 0; i < 4; i++)
			check_value("cache line word", models.cmem[{line, 2'(i)}], w[i]);
		check_stream(line, w);
	endtask

	// --------------------------------------------------
	task automatic test_read_miss();
		read_miss_expect(tags[0], 0);  // first victim is line zero
	endtask

	task automatic test_read_hit_stall();
		logic [DATA_W-1:0] w [0:3];
		for (int i = 0; i < 4; i++)
			w[i] = fill_word({tags[0], 2'(i)});
		clear_logs();
		L2_ready_write_i = 1'b0;  // L1 not ready yet
		L1_tag_i = tags[0];
		L1_rw_i  = 1'b0;
		L1_req_i = 1'b1;
		tick();
		L1_req_i = 1'b0;
		repeat (6) tick();
		check_value("L1_valid_o count", v_cnt, 0);
		check_value("L1_done_o", L1_done_o, 0);
		check_value("L1_hit_o", L1_hit_o, 1);
		L2_ready_write_i = 1'b1;
		wait_done();
		check_value("flag_hit_o count", hit_cnt, 1);
		check_value("flag_miss_o count", miss_cnt, 0);
		check_stream(0, w);
	endtask

	task automatic test_write_hit();
		clear_logs();
		load_l1_block();
		issue_req(1'b1, tags[0], 1'b1);
		check_value("L2_read_ack_o count", ack_cnt, 4);
		check_value("flag_hit_o count", hit_cnt, 1);
		check_value("mem_req_o count", cmd_cnt, 0);
		for (int i = 0; i < 4; i++) begin
			wh_words[i] = l1_tx[i];
			check_value("cache line word", models.cmem[{3'd0, 2'(i)}], l1_tx[i]);
		end
	endtask

	task automatic test_write_miss();
		clear_logs();
		load_l1_block();
		issue_req(1'b1, tags[1], 1'b0);
		check_value("flag_miss_o count", miss_cnt, 1);
		check_value("mem_req_o count", cmd_cnt, 0);  // no fetch on a write miss
		check_value("cam_wren_o count", cam_cnt, 1);
		check_value("cam_addr_o", cam_line[0], 1);
		check_value("CAM tag line 1", models.cam_tag[1], tags[1]);
		for (int i = 0; i < 4; i++) begin
			wm_words[i] = l1_tx[i];
			check_value("cache line word", models.cmem[{3'd1, 2'(i)}], l1_tx[i]);
		end
	endtask

	task automatic test_dirty_evict();
		for (int k = 2; k < 8; k++)
			read_miss_expect(tags[k], LINE_W'(k));
		clear_logs();
		issue_req(1'b0, tags[8], 1'b0);  // pointer wraps onto dirty line zero
		check_value("flag_writeback_o count", wb_cnt, 1);
		check_value("mem_req_o count", cmd_cnt, 2);
		check_value("fill mem_rw_o", cmd_rw[0], 0);
		check_value("fill mem_addr_o", cmd_addr[0], {tags[8], 2'b00});
		check_value("writeback mem_rw_o", cmd_rw[1], 1);
		check_value("writeback mem_req_block_o", cmd_blk[1], 1);
		check_value("writeback mem_addr_o", cmd_addr[1], {tags[0], 2'b00});
		check_value("write buffer count", models.wq_cnt, 4);
		for (int i = 0; i < 4; i++) begin
			check_value("write buffer word", models.wq[i], wh_words[i]);
			check_value("cache line word", models.cmem[{3'd0, 2'(i)}],
				fill_word({tags[8], 2'(i)}));
		end
		check_value("CAM tag line 0", models.cam_tag[0], tags[8]);
	endtask

	task automatic test_enable_pause();
		int held;
		clear_logs();
		L2_ready_write_i = 1'b1;
		L1_tag_i = tags[1];
		L1_rw_i  = 1'b0;
		L1_req_i = 1'b1;
		tick();
		L1_req_i = 1'b0;
		while (v_cnt < 2)
			tick();
		enable_i = 1'b0;  // freeze mid block
		tick();
		held = v_cnt;
		repeat (6) begin
			tick();
			check_value("L1_valid_o", L1_valid_o, 0);
			check_value("L1_done_o", L1_done_o, 0);
		end
		check_value("L1_valid_o count", v_cnt, held);
		enable_i = 1'b1;
		wait_done();
		check_value("flag_hit_o count", hit_cnt, 1);
		check_stream(1, wm_words);
	endtask

	// --------------------------------------------------
	initial begin
		void'($urandom(32'hb4a6_cf4d));
		clear_logs();
		l1_idx           = 4;
		resetn_i         = 1'b0;
		enable_i         = 1'b1;
		mem_ready_i      = 1'b1;
		L1_req_i         = 1'b0;
		L1_rw_i          = 1'b0;
		L1_tag_i         = '0;
		L1_data_i        = '0;
		L2_ready_read_i  = 1'b0;
		L2_ready_write_i = 1'b0;
		for (int i = 0; i < 9; i++)
			tags[i] = {18'($urandom), 4'(i)};  // low bits keep tags distinct
		repeat (2) tick();
		resetn_i = 1'b1;
		check_value("L1_done_o", L1_done_o, 1);
		check_value("mem_req_o", mem_req_o, 0);
		check_value("cam_wren_o", cam_wren_o, 0);
		check_value("L1_valid_o", L1_valid_o, 0);
		tick();
		test_read_miss();
		test_read_hit_stall();
		test_write_hit();
		test_write_miss();
		test_dirty_evict();
		test_enable_pause();
		$display("** PASS **");
		$finish;
	end

endmodule

//--- verif/tb_l2_models.sv
`timescale 1ns/1ps

// tag CAM, cache data memory, read/write word buffers and a main memory that answers block reads
module tb_l2_models import l2_cache_pkg::*; #(
	parameter logic [DATA_W-1:0] FILL_PATTERN = 32'h0
) (
	input  logic                   clock_i,
	input  logic                   resetn_i,
	input  logic [TAG_W-1:0]       match_tag_i,   // L1 request tag, also the tag written
	output logic                   hit_o,
	output logic [LINE_W-1:0]      hit_line_o,
	input  logic [LINE_W-1:0]      sel_line_i,    // line the controller points at
	output logic [TAG_W-1:0]       sel_tag_o,
	input  logic                   wren_i,
	input  logic [CMEM_ADDR_W-1:0] cmem_add_i,
	input  logic                   cmem_rw_i,
	input  logic [DATA_W-1:0]      cmem_wdata_i,
	output logic [DATA_W-1:0]      cmem_rdata_o,
	output logic                   rbuf_ready_o,
	output logic [DATA_W-1:0]      rbuf_data_o,
	input  logic                   rbuf_ack_i,
	output logic                   wbuf_ready_o,
	input  logic [DATA_W-1:0]      wbuf_data_i,
	input  logic                   wbuf_ack_i,
	input  logic                   mem_req_i,
	input  logic                   mem_rw_i,
	input  logic [WORD_ADDR_W-1:0] mem_addr_i
);

	logic [TAG_W-1:0]  cam_tag [0:CACHE_LINES-1];
	logic              cam_vld [0:CACHE_LINES-1];
	logic [DATA_W-1:0] cmem    [0:(1<<CMEM_ADDR_W)-1];
	logic [DATA_W-1:0] rq      [0:15];  // read buffer ring
	logic [3:0]        rd_ptr;
	logic [3:0]        wr_ptr;
	logic [DATA_W-1:0] wq      [0:15];  // write buffer, inspected by the testbench
	int                wq_cnt;

	// --------------------------------------------------
	// tag CAM, combinational match
	always @* begin
		hit_o      = 1'b0;
		hit_line_o = '0;
		for (int i = 0; i < CACHE_LINES; i++)
			if (cam_vld[i] && cam_tag[i] == match_tag_i) begin
				hit_o      = 1'b1;
				hit_line_o = LINE_W'(i);
			end
	end
	assign sel_tag_o = cam_tag[sel_line_i];

	initial begin
		for (int i = 0; i < (1 << CMEM_ADDR_W); i++)
			cmem[i] = 32'hc0de_0000 | (i * 32'h0001_0101);  // address dependent junk
	end

	assign cmem_rdata_o = cmem[cmem_add_i];                   // async read
	assign rbuf_ready_o = (rd_ptr != wr_ptr) && !rbuf_ack_i;  // one word per ack
	assign rbuf_data_o  = rq[rd_ptr];
	assign wbuf_ready_o = 1'b1;                               // never full

	always @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int i = 0; i < CACHE_LINES; i++)
				cam_vld[i] <= 1'b0;
			rd_ptr <= '0;
			wr_ptr <= '0;
			wq_cnt <= 0;
		end else begin
			if (wren_i) begin
				cam_tag[sel_line_i] <= match_tag_i;
				cam_vld[sel_line_i] <= 1'b1;
			end
			if (cmem_rw_i)
				cmem[cmem_add_i] <= cmem_wdata_i;
			if (mem_req_i && !mem_rw_i) begin  // block read lands in the read buffer
				for (int i = 0; i < WORDS_PER_BLOCK; i++)
					rq[wr_ptr + 4'(i)] <= {8'h00, mem_addr_i + WORD_ADDR_W'(i)} ^ FILL_PATTERN;
				wr_ptr <= wr_ptr + 4'(WORDS_PER_BLOCK);
			end
			if (rbuf_ack_i)
				rd_ptr <= rd_ptr + 1'b1;
			if (wbuf_ack_i) begin
				wq[wq_cnt] <= wbuf_data_i;
				wq_cnt     <= wq_cnt + 1;
			end
		end
	end

endmodule

//--- verilog/l2_access_fsm.sv
`timescale 1ns/1ps

module l2_access_fsm import l2_cache_pkg::*; (
	input  logic                   clock_i,
	input  logic                   resetn_i,
	input  logic                   enable_i,
	input  logic                   L1_req_i,
	input  logic                   L1_rw_i,             // 1: L1 writes a block back
	input  logic [TAG_W-1:0]       L1_tag_i,
	input  logic [DATA_W-1:0]      L1_data_i,
	input  logic                   L2_ready_read_i,     // L1 has a word for us
	input  logic                   L2_ready_write_i,    // L1 can take a word
	output logic                   L1_done_o,
	output logic                   L1_hit_o,
	output logic                   L1_valid_o,
	output logic                   L2_read_ack_o,
	input  logic                   cam_hit_i,
	input  logic [TAG_W-1:0]       cam_tag_i,           // tag stored at cam_addr_o
	input  logic [LINE_W-1:0]      cam_addr_i,          // line matching L1_tag_i
	output logic                   cam_wren_o,
	output logic [LINE_W-1:0]      cam_addr_o,
	input  logic [DATA_W-1:0]      cache_mem_data_i,
	output logic [CMEM_ADDR_W-1:0] cache_mem_add_o,
	output logic                   cache_mem_rw_o,
	output logic [DATA_W-1:0]      cache_mem_data_o,
	input  logic                   buffer_read_ready_i,
	input  logic [DATA_W-1:0]      buffer_data_i,
	output logic                   buffer_read_ack_o,
	input  logic                   buffer_write_ready_i,
	output logic [DATA_W-1:0]      buffer_data_o,
	output logic                   buffer_write_ack_o,
	output logic                   flag_hit_o,
	output logic                   flag_miss_o,
	output logic                   flag_writeback_o,
	output logic                   victim_adv_o,
	input  logic [LINE_W-1:0]      victim_line_i,
	input  logic                   victim_dirty_i,
	output logic                   set_dirty_o,
	output logic                   clr_dirty_o,
	output logic [LINE_W-1:0]      dirty_line_o,
	mem_cmd_if.seq                 cmd
);

	ctrl_state_t        state_q;
	logic [BLOCK_W:0]   word_cnt;    // words moved in the current block
	logic [BLOCK_W:0]   word_nxt;
	logic               last_word;
	logic               req_flag_q;  // miss pending, replay as a hit afterwards
	logic               rw_flag_q;   // registered request type
	logic               rw_now;

	assign word_nxt  = word_cnt + 1'b1;
	assign last_word = (word_cnt == LAST_WORD);
	assign rw_now    = req_flag_q ? rw_flag_q : L1_rw_i;  // replay keeps the stored type

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q            <= NORMAL;
			word_cnt           <= '0;
			req_flag_q         <= 1'b0;
			rw_flag_q          <= 1'b0;
			L1_done_o          <= 1'b1;  // nothing pending, L1 may issue
			L1_hit_o           <= 1'b1;
			L1_valid_o         <= 1'b0;
			L2_read_ack_o      <= 1'b0;
			cam_wren_o         <= 1'b0;
			cache_mem_rw_o     <= 1'b0;
			buffer_read_ack_o  <= 1'b0;
			buffer_write_ack_o <= 1'b0;
			flag_hit_o         <= 1'b0;
			flag_miss_o        <= 1'b0;
			flag_writeback_o   <= 1'b0;
			victim_adv_o       <= 1'b0;
			set_dirty_o        <= 1'b0;
			clr_dirty_o        <= 1'b0;
			cmd.fill_req       <= 1'b0;
			cmd.wb_load        <= 1'b0;
		end else begin
			// strobes are single cycle
			L1_valid_o         <= 1'b0;
			L2_read_ack_o      <= 1'b0;
			cam_wren_o         <= 1'b0;
			cache_mem_rw_o     <= 1'b0;
			buffer_read_ack_o  <= 1'b0;
			buffer_write_ack_o <= 1'b0;
			flag_hit_o         <= 1'b0;
			flag_miss_o        <= 1'b0;
			flag_writeback_o   <= 1'b0;
			victim_adv_o       <= 1'b0;
			set_dirty_o        <= 1'b0;
			clr_dirty_o        <= 1'b0;
			cmd.wb_load        <= 1'b0;
			if (cmd.fill_ack)
				cmd.fill_req <= 1'b0;  // handshake closes even while disabled

			if (enable_i) begin
				case (state_q)
					// --------------------------------------------------
					NORMAL: begin
						if (L1_req_i || req_flag_q) begin
							L1_done_o <= 1'b0;  // stall L1
							L1_hit_o  <= cam_hit_i;
							if (cam_hit_i) begin
								word_cnt   <= '0;
								req_flag_q <= 1'b0;
								rw_flag_q  <= rw_now;
								flag_hit_o <= !req_flag_q;  // a replayed miss is no new hit
								if (rw_now) begin
									set_dirty_o  <= 1'b1;  // L1 block now newer than memory
									dirty_line_o <= cam_addr_i;
									state_q      <= HIT_FROM_L1;
								end else begin
									state_q <= HIT_TO_L1;
								end
							end else begin
								flag_miss_o   <= 1'b1;
								victim_adv_o  <= 1'b1;
								req_flag_q    <= 1'b1;
								rw_flag_q     <= L1_rw_i;
								cmd.fill_req  <= !L1_rw_i;  // write miss needs no fetch
								cmd.fill_addr <= {L1_tag_i, {BLOCK_W{1'b0}}};
								state_q       <= WAIT_FILL_CMD;
							end
						end else begin
							L1_hit_o <= 1'b1;
						end
					end

					HIT_TO_L1: if (L2_ready_write_i) begin
						L1_valid_o      <= 1'b1;
						cache_mem_add_o <= {cam_addr_i, word_cnt[BLOCK_W-1:0]};
						word_cnt        <= last_word ? '0 : word_nxt;
						if (last_word) begin
							L1_done_o <= 1'b1;
							state_q   <= NORMAL;
						end
					end

					HIT_FROM_L1: if (L2_ready_read_i) begin
						L2_read_ack_o    <= 1'b1;  // pop the L1 transmit word
						cache_mem_rw_o   <= 1'b1;
						cache_mem_add_o  <= {cam_addr_i, word_cnt[BLOCK_W-1:0]};
						cache_mem_data_o <= L1_data_i;
						word_cnt         <= last_word ? '0 : word_nxt;
						if (last_word) begin
							L1_done_o <= 1'b1;
							state_q   <= NORMAL;
						end
					end

					// --------------------------------------------------
					// miss handling
					WAIT_FILL_CMD: if (!cmd.fill_req || cmd.fill_ack)
						state_q <= VICTIM;  // victim pointer has settled by now

					VICTIM: begin
						cam_addr_o      <= victim_line_i;  // old tag shows on cam_tag_i
						cache_mem_add_o <= {victim_line_i, {BLOCK_W{1'b0}}};
						word_cnt        <= '0;
						if (victim_dirty_i) begin
							flag_writeback_o <= 1'b1;
							state_q          <= WRITE_BUFFER;
						end else begin
							state_q <= rw_flag_q ? FILL_L1 : FILL_MEM;
						end
					end

					WRITE_BUFFER: if (buffer_write_ready_i) begin
						buffer_write_ack_o <= 1'b1;
						buffer_data_o      <= cache_mem_data_i;
						cache_mem_add_o    <= {victim_line_i, word_nxt[BLOCK_W-1:0]};  // prefetch
						word_cnt           <= last_word ? '0 : word_nxt;
						if (word_cnt == '0) begin
							cmd.wb_load <= 1'b1;
							cmd.wb_addr <= {cam_tag_i, {BLOCK_W{1'b0}}};
						end
						if (last_word) begin
							clr_dirty_o  <= 1'b1;
							dirty_line_o <= victim_line_i;
							state_q      <= rw_flag_q ? FILL_L1 : FILL_MEM;
						end
					end

					FILL_MEM: if (buffer_read_ready_i) begin
						buffer_read_ack_o <= 1'b1;
						cache_mem_rw_o    <= 1'b1;
						cache_mem_add_o   <= {victim_line_i, word_cnt[BLOCK_W-1:0]};
						cache_mem_data_o  <= buffer_data_i;
						word_cnt          <= last_word ? '0 : word_nxt;
						if (last_word) begin
							cam_wren_o <= 1'b1;  // CAM takes L1_tag_i
							cam_addr_o <= victim_line_i;
							state_q    <= TAG_WAIT;
						end
					end

					FILL_L1: if (L2_ready_read_i) begin
						L2_read_ack_o    <= 1'b1;
						cache_mem_rw_o   <= 1'b1;
						cache_mem_add_o  <= {victim_line_i, word_cnt[BLOCK_W-1:0]};
						cache_mem_data_o <= L1_data_i;
						word_cnt         <= last_word ? '0 : word_nxt;
						if (last_word) begin
							cam_wren_o   <= 1'b1;
							cam_addr_o   <= victim_line_i;
							set_dirty_o  <= 1'b1;
							dirty_line_o <= victim_line_i;
							req_flag_q   <= 1'b0;  // write already served, no replay
							L1_done_o    <= 1'b1;
							state_q      <= TAG_WAIT;
						end
					end

					TAG_WAIT: state_q <= NORMAL;

					default: state_q <= NORMAL;
				endcase
			end
		end
	end

	// --------------------------------------------------
	a_word_cnt: assert property (@(posedge clock_i) disable iff (!resetn_i)
		word_cnt <= LAST_WORD);
	// tag is written only on the cycle after the last fill word
	a_tag_after_fill: assert property (@(posedge clock_i) disable iff (!resetn_i)
		cam_wren_o |-> $past(state_q) inside {FILL_MEM, FILL_L1});

endmodule

//--- verilog/l2_cache_ctrl.sv
`timescale 1ns/1ps

module l2_cache_ctrl import l2_cache_pkg::*; (
	input  logic                   clock_i,
	input  logic                   resetn_i,
	input  logic                   enable_i,
	// L1 side
	input  logic                   L1_req_i,
	input  logic                   L1_rw_i,
	input  logic [TAG_W-1:0]       L1_tag_i,
	input  logic [DATA_W-1:0]      L1_data_i,
	input  logic                   L2_ready_read_i,
	input  logic                   L2_ready_write_i,
	output logic                   L1_done_o,
	output logic                   L1_hit_o,
	output logic                   L1_valid_o,
	output logic                   L2_read_ack_o,
	// tag CAM
	input  logic                   cam_hit_i,
	input  logic [TAG_W-1:0]       cam_tag_i,
	input  logic [LINE_W-1:0]      cam_addr_i,
	output logic                   cam_wren_o,
	output logic [LINE_W-1:0]      cam_addr_o,
	// cache data memory
	input  logic [DATA_W-1:0]      cache_mem_data_i,
	output logic [CMEM_ADDR_W-1:0] cache_mem_add_o,
	output logic                   cache_mem_rw_o,
	output logic [DATA_W-1:0]      cache_mem_data_o,
	// main memory word buffers
	input  logic                   buffer_read_ready_i,
	input  logic [DATA_W-1:0]      buffer_data_i,
	output logic                   buffer_read_ack_o,
	input  logic                   buffer_write_ready_i,
	output logic [DATA_W-1:0]      buffer_data_o,
	output logic                   buffer_write_ack_o,
	// memory command port
	input  logic                   mem_ready_i,
	output logic                   mem_req_o,
	output logic                   mem_req_block_o,
	output logic                   mem_rw_o,
	output logic [WORD_ADDR_W-1:0] mem_addr_o,
	// performance flags
	output logic                   flag_hit_o,
	output logic                   flag_miss_o,
	output logic                   flag_writeback_o
);

	// sequencer <-> victim tracker
	logic              victim_adv;
	logic [LINE_W-1:0] victim_line;
	logic              victim_dirty;
	logic              set_dirty;
	logic              clr_dirty;
	logic [LINE_W-1:0] dirty_line;

	mem_cmd_if mem_cmd_bus ();  // fill and writeback requests

	// --------------------------------------------------
	// same-named top ports connect by name
	l2_access_fsm u_seq (
		.*,
		.victim_adv_o   (victim_adv),
		.victim_line_i  (victim_line),
		.victim_dirty_i (victim_dirty),
		.set_dirty_o    (set_dirty),
		.clr_dirty_o    (clr_dirty),
		.dirty_line_o   (dirty_line),
		.cmd            (mem_cmd_bus.seq)
	);

	l2_victim_track u_victim (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.victim_adv_i   (victim_adv),
		.set_dirty_i    (set_dirty),
		.clr_dirty_i    (clr_dirty),
		.dirty_line_i   (dirty_line),
		.victim_line_o  (victim_line),
		.victim_dirty_o (victim_dirty)
	);

	l2_mem_cmd u_mem_cmd (
		.*,
		.cmd            (mem_cmd_bus.cmd)
	);

endmodule

//--- verilog/l2_cache_pkg.sv
package l2_cache_pkg;

	// --------------------------------------------------
	// address and data geometry
	// --------------------------------------------------
	localparam int WORD_ADDR_W     = 24;                     // main memory word address
	localparam int BLOCK_W         = 2;                      // word offset inside a block
	localparam int WORDS_PER_BLOCK = 2 ** BLOCK_W;           // four words per block
	localparam int CACHE_LINES     = 8;                      // fully associative, no sets
	localparam int LINE_W          = $clog2(CACHE_LINES);    // line index width
	localparam int TAG_W           = WORD_ADDR_W - BLOCK_W;  // whole block address is the tag
	localparam int CMEM_ADDR_W     = LINE_W + BLOCK_W;       // {line, word} into cache data memory
	localparam int DATA_W          = 32;

	// value of the word counter on the last word of a block
	localparam logic [BLOCK_W:0] LAST_WORD = (BLOCK_W + 1)'(WORDS_PER_BLOCK - 1);

	// --------------------------------------------------
	// access sequencer states
	// --------------------------------------------------
	typedef enum logic [3:0] {
		NORMAL,         // idle, look up the L1 request in the CAM
		HIT_TO_L1,      // read hit, stream the line out to L1
		HIT_FROM_L1,    // write hit, take the block from L1
		WAIT_FILL_CMD,  // victim pointer moves, fill read goes out
		VICTIM,         // check the dirty bit of the chosen line
		WRITE_BUFFER,   // copy a dirty victim into the write buffer
		FILL_MEM,       // read miss, block comes in from the read buffer
		FILL_L1,        // write miss, block comes straight from L1
		TAG_WAIT        // tag write needs one extra cycle in the CAM
	} ctrl_state_t;

endpackage

//--- verilog/l2_mem_cmd.sv
`timescale 1ns/1ps

module l2_mem_cmd import l2_cache_pkg::*; (
	input  logic                   clock_i,
	input  logic                   resetn_i,
	input  logic                   mem_ready_i,
	mem_cmd_if.cmd                 cmd,
	output logic                   mem_req_o,
	output logic                   mem_req_block_o,
	output logic                   mem_rw_o,
	output logic [WORD_ADDR_W-1:0] mem_addr_o
);

	logic                   wb_pend_q;  // one deferred block write
	logic [WORD_ADDR_W-1:0] wb_addr_q;
	logic                   fill_go;
	logic                   wb_go;

	// fill reads win, writebacks wait for an idle ready cycle
	assign fill_go = cmd.fill_req && mem_ready_i && !mem_req_o;
	assign wb_go   = wb_pend_q && mem_ready_i && !cmd.fill_req && !mem_req_o;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			mem_req_o       <= 1'b0;
			mem_req_block_o <= 1'b0;
			mem_rw_o        <= 1'b0;
			cmd.fill_ack    <= 1'b0;
			wb_pend_q       <= 1'b0;
		end else begin
			mem_req_o       <= fill_go || wb_go;
			mem_req_block_o <= fill_go || wb_go;  // whole blocks only
			mem_rw_o        <= wb_go;             // 1 = block write
			cmd.fill_ack    <= fill_go;
			if (wb_go)
				wb_pend_q <= 1'b0;
			if (cmd.wb_load)
				wb_pend_q <= 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (cmd.wb_load)
			wb_addr_q <= cmd.wb_addr;
		if (fill_go)
			mem_addr_o <= cmd.fill_addr;
		else if (wb_go)
			mem_addr_o <= wb_addr_q;
	end

	a_req_gap: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_req_o |=> !mem_req_o);
	// sequencer only parks a writeback once the previous one has gone out
	a_wb_single: assert property (@(posedge clock_i) disable iff (!resetn_i)
		cmd.wb_load |-> !wb_pend_q);

endmodule

//--- verilog/l2_victim_track.sv
`timescale 1ns/1ps

module l2_victim_track import l2_cache_pkg::*; (
	input  logic              clock_i,
	input  logic              resetn_i,
	input  logic              victim_adv_i,   // pulse per miss
	input  logic              set_dirty_i,
	input  logic              clr_dirty_i,
	input  logic [LINE_W-1:0] dirty_line_i,
	output logic [LINE_W-1:0] victim_line_o,
	output logic              victim_dirty_o
);

	logic [CACHE_LINES-1:0] dirty_q;  // one bit per line

	assign victim_dirty_o = dirty_q[victim_line_o];

	// --------------------------------------------------
	// round-robin pointer and dirty bits
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			victim_line_o <= '1;  // first advance wraps to line zero
			dirty_q       <= '0;
		end else begin
			if (victim_adv_i)
				victim_line_o <= victim_line_o + 1'b1;
			if (set_dirty_i)
				dirty_q[dirty_line_i] <= 1'b1;
			if (clr_dirty_i)
				dirty_q[dirty_line_i] <= 1'b0;
		end
	end

	// sequencer never marks and cleans a line together
	a_set_clr: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!(set_dirty_i && clr_dirty_i));

endmodule

//--- verilog/mem_cmd_if.sv
`timescale 1ns/1ps

// request path from the access sequencer to the memory command unit
interface mem_cmd_if import l2_cache_pkg::*; ();

	logic                   fill_req;   // level, held until fill_ack
	logic [WORD_ADDR_W-1:0] fill_addr;  // block address, word zero
	logic                   fill_ack;   // one cycle, read command has gone out
	logic                   wb_load;    // one cycle, park a writeback address
	logic [WORD_ADDR_W-1:0] wb_addr;    // old tag with word zero

	// sequencer side
	modport seq (
		output fill_req,
		output fill_addr,
		output wb_load,
		output wb_addr,
		input  fill_ack
	);

	// command unit side
	modport cmd (
		input  fill_req,
		input  fill_addr,
		input  wb_load,
		input  wb_addr,
		output fill_ack
	);

endinterface
